// File: include/acc_cpu_config.svh
`ifndef ACC_CPU_CONFIG_SVH
`define ACC_CPU_CONFIG_SVH

// machine word, both data and instruction
`define WORD_W 16

// word address into main memory
`define ADDR_W 12

// number of words, one full address space
`define MEM_DEPTH 4096

// output channel credits available after reset
// consumer may hold at most this many beats unacknowledged
`define OUT_CREDITS 4

`endif

// File: design/acc_cpu_pkg.sv
`include "acc_cpu_config.svh"

package acc_cpu_pkg;

    // top nibble of every instruction
    // codes not listed here execute as no-op
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_LOAD  = 4'h1,
        OP_STORE = 4'h2,
        OP_ALUI  = 4'h3,
        OP_JUMP  = 4'h4,
        OP_JZ    = 4'h5,
        OP_OUT   = 4'h6,
        OP_HALT  = 4'hf
    } opcode_e;

    // alu function select, same order as the original alu block
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_MUL  = 4'h2,
        ALU_DIV  = 4'h3,
        ALU_SHL  = 4'h4,
        ALU_SHR  = 4'h5,
        ALU_ROL  = 4'h6,
        ALU_ROR  = 4'h7,
        ALU_AND  = 4'h8,
        ALU_OR   = 4'h9,
        ALU_XOR  = 4'ha,
        ALU_NOR  = 4'hb,
        ALU_NAND = 4'hc,
        ALU_XNOR = 4'hd,
        ALU_GT   = 4'he,
        ALU_EQ   = 4'hf
    } alu_func_e;

    // one instruction word, two decodes
    // memory form for load/store/jumps, alu form for alui
    typedef union packed {
        struct packed {
            opcode_e            opcode;
            logic [`ADDR_W-1:0] addr;
        } mem;
        struct packed {
            opcode_e    opcode;
            alu_func_e  func;
            logic [7:0] imm;
        } alu;
    } instr_u;

endpackage

// File: design/alu.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module alu (
    input  acc_cpu_pkg::alu_func_e func,
    input  logic [`WORD_W-1:0]     a,
    input  logic [`WORD_W-1:0]     b,
    output logic [`WORD_W-1:0]     result
);
    import acc_cpu_pkg::*;

    // full product, only the low word is kept
    logic [2*`WORD_W-1:0] product;

    assign product = a * b;

    always_comb begin
        case (func)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_MUL:  result = product[`WORD_W-1:0];
            // divide by zero gives all ones
            ALU_DIV:  result = (b == '0) ? '1 : a / b;
            // shifts and rotates use a only, by one bit
            ALU_SHL:  result = {a[`WORD_W-2:0], 1'b0};
            ALU_SHR:  result = {1'b0, a[`WORD_W-1:1]};
            ALU_ROL:  result = {a[`WORD_W-2:0], a[`WORD_W-1]};
            ALU_ROR:  result = {a[0], a[`WORD_W-1:1]};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_NAND: result = ~(a & b);
            ALU_XNOR: result = ~(a ^ b);
            // compares return 1 or 0, unsigned
            ALU_GT:   result = {{(`WORD_W-1){1'b0}}, (a > b)};
            ALU_EQ:   result = {{(`WORD_W-1){1'b0}}, (a == b)};
            // unknown select, e.g. before first ir load
            default:  result = '0;
        endcase
    end

endmodule

// File: design/main_memory.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module main_memory (
    input  logic               clk,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`WORD_W-1:0] wdata,
    input  logic               we,
    output logic [`WORD_W-1:0] rdata
);

    // one word per address, whole address space
    logic [`WORD_W-1:0] mem [0:`MEM_DEPTH-1];

    // single port
    // write wins, rdata holds its old value on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            // registered read, valid the cycle after addr
            rdata <= mem[addr];
        end
    end

    // loader and cpu both drive addr through the top mux
    // a write to an unknown address would corrupt the array
    a_we_addr_known: assert property (
        @(posedge clk) we |-> !$isunknown(addr)
    ) else $error("main_memory: write with unknown address");

endmodule

// File: design/program_counter.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module program_counter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inc,
    input  logic               jump,
    input  logic               clear,
    input  logic [`ADDR_W-1:0] target,
    output logic [`ADDR_W-1:0] pc
);

    // clear beats jump beats increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;
        end else if (jump) begin
            pc <= target;
        end else if (inc) begin
            // wrap at the top of memory
            pc <= (pc == `ADDR_W'(`MEM_DEPTH - 1)) ? '0 : pc + 1'b1;
        end
    end

    // sequencer raises these in different states
    // two at once means the fsm decode is broken
    a_one_ctrl: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({inc, jump, clear})
    ) else $error("program_counter: more than one control active");

endmodule

// File: design/datapath.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mar_from_pc,
    input  logic                 mar_from_ir,
    input  logic                 mbr_load,
    input  logic                 ir_load,
    input  logic                 acc_from_mbr,
    input  logic                 acc_from_alu,
    input  logic [`ADDR_W-1:0]   pc,
    input  logic [`WORD_W-1:0]   mem_rdata,
    output logic [`ADDR_W-1:0]   mem_addr,
    output logic [`WORD_W-1:0]   mem_wdata,
    output acc_cpu_pkg::opcode_e opcode,
    output logic [`ADDR_W-1:0]   jump_target,
    output logic                 acc_zero,
    output logic [`WORD_W-1:0]   acc
);
    import acc_cpu_pkg::*;

    logic [`ADDR_W-1:0] mar;
    logic [`WORD_W-1:0] mbr;
    instr_u             ir;
    logic [`WORD_W-1:0] alu_b;
    logic [`WORD_W-1:0] alu_result;

    // mar and mbr are plain payload
    always_ff @(posedge clk) begin
        if (mar_from_pc) begin
            mar <= pc;
        end else if (mar_from_ir) begin
            mar <= ir.mem.addr;
        end
        if (mbr_load) begin
            mbr <= mem_rdata;
        end
    end

    // ir resets to a no-op, acc to zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir  <= '0;
            acc <= '0;
        end else begin
            if (ir_load) begin
                ir <= mem_rdata;
            end
            if (acc_from_mbr) begin
                acc <= mbr;
            end else if (acc_from_alu) begin
                acc <= alu_result;
            end
        end
    end

    // operand address goes straight out while mar loads from ir
    // lets load/store reach memory in the same cycle
    assign mem_addr    = mar_from_ir ? ir.mem.addr : mar;
    assign mem_wdata   = acc;

    // memory view of the ir
    assign opcode      = ir.mem.opcode;
    assign jump_target = ir.mem.addr;
    assign acc_zero    = (acc == '0);

    // alu view of the ir, immediate zero extended
    assign alu_b = `WORD_W'(ir.alu.imm);

    alu u_alu (
        .func   (ir.alu.func),
        .a      (acc),
        .b      (alu_b),
        .result (alu_result)
    );

    // one acc source per cycle
    a_acc_one_src: assert property (
        @(posedge clk) disable iff (!rst_n) !(acc_from_mbr && acc_from_alu)
    ) else $error("datapath: accumulator loaded from mbr and alu together");

endmodule

// File: design/control_fsm.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module control_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  acc_cpu_pkg::opcode_e opcode,
    input  logic                 acc_zero,
    input  logic                 credit_return,
    output logic                 pc_inc,
    output logic                 pc_jump,
    output logic                 pc_clear,
    output logic                 mar_from_pc,
    output logic                 mar_from_ir,
    output logic                 mbr_load,
    output logic                 ir_load,
    output logic                 acc_from_mbr,
    output logic                 acc_from_alu,
    output logic                 mem_we,
    output logic                 out_valid,
    output logic                 running,
    output logic                 halted
);
    import acc_cpu_pkg::*;

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_FETCH     = 3'd1;
    localparam logic [2:0] S_WAIT      = 3'd2;
    localparam logic [2:0] S_DECODE    = 3'd3;
    localparam logic [2:0] S_EXEC      = 3'd4;
    localparam logic [2:0] S_LOAD_WAIT = 3'd5;
    localparam logic [2:0] S_LOAD_WB   = 3'd6;

    // enough bits to hold a full credit count
    localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

    logic [2:0]        state;
    logic [2:0]        state_next;
    logic [CRED_W-1:0] credits;
    logic              have_credit;
    logic              halted_q;

    assign have_credit = (credits != '0);

    always_comb begin
        state_next   = state;
        pc_inc       = 1'b0;
        pc_jump      = 1'b0;
        pc_clear     = 1'b0;
        mar_from_pc  = 1'b0;
        mar_from_ir  = 1'b0;
        mbr_load     = 1'b0;
        ir_load      = 1'b0;
        acc_from_mbr = 1'b0;
        acc_from_alu = 1'b0;
        mem_we       = 1'b0;
        out_valid    = 1'b0;
        case (state)
            S_IDLE: begin
                // program always starts at address 0
                if (start) begin
                    pc_clear   = 1'b1;
                    state_next = S_FETCH;
                end
            end
            S_FETCH: begin
                mar_from_pc = 1'b1;
                state_next  = S_WAIT;
            end
            // memory read of mar
            S_WAIT: state_next = S_DECODE;
            S_DECODE: begin
                ir_load    = 1'b1;
                mbr_load   = 1'b1;
                pc_inc     = 1'b1;
                state_next = S_EXEC;
            end
            S_EXEC: begin
                state_next = S_FETCH;
                case (opcode)
                    OP_LOAD: begin
                        // read issued this cycle via the address bypass
                        mar_from_ir = 1'b1;
                        state_next  = S_LOAD_WAIT;
                    end
                    OP_STORE: begin
                        mar_from_ir = 1'b1;
                        mem_we      = 1'b1;
                    end
                    OP_ALUI: acc_from_alu = 1'b1;
                    OP_JUMP: pc_jump = 1'b1;
                    OP_JZ:   pc_jump = acc_zero;
                    OP_OUT: begin
                        // no credit, hold here until one comes back
                        out_valid = have_credit;
                        if (!have_credit) begin
                            state_next = S_EXEC;
                        end
                    end
                    OP_HALT: state_next = S_IDLE;
                    // unused codes fall through as no-op
                    default: state_next = S_FETCH;
                endcase
            end
            S_LOAD_WAIT: begin
                mbr_load   = 1'b1;
                state_next = S_LOAD_WB;
            end
            S_LOAD_WB: begin
                acc_from_mbr = 1'b1;
                state_next   = S_FETCH;
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            halted_q <= 1'b0;
            credits  <= CRED_W'(`OUT_CREDITS);
        end else begin
            state <= state_next;
            // halted holds until the next start
            if (state == S_IDLE && start) begin
                halted_q <= 1'b0;
            end else if (state == S_EXEC && opcode == OP_HALT) begin
                halted_q <= 1'b1;
            end
            // spend one per beat, regain one per return
            credits <= credits + CRED_W'(credit_return) - CRED_W'(out_valid);
        end
    end

    assign running = (state != S_IDLE);
    assign halted  = halted_q;

    a_valid_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> have_credit
    ) else $error("control_fsm: out_valid with no credit");

    // consumer must not return more than it was sent
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) credits <= CRED_W'(`OUT_CREDITS)
    ) else $error("control_fsm: credit count above limit");

    // start is only meaningful from idle
    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !running
    ) else $error("control_fsm: start while running");

endmodule

// File: design/acc_cpu_top.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module acc_cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_en,
    input  logic [`ADDR_W-1:0] load_addr,
    input  logic [`WORD_W-1:0] load_data,
    input  logic               start,
    input  logic               credit_return,
    output logic               out_valid,
    output logic [`WORD_W-1:0] out_data,
    output logic               running,
    output logic               halted
);
    import acc_cpu_pkg::*;

    logic               pc_inc;
    logic               pc_jump;
    logic               pc_clear;
    logic               mar_from_pc;
    logic               mar_from_ir;
    logic               mbr_load;
    logic               ir_load;
    logic               acc_from_mbr;
    logic               acc_from_alu;
    logic               cpu_we;
    opcode_e            opcode;
    logic               acc_zero;
    logic [`ADDR_W-1:0] pc;
    logic [`ADDR_W-1:0] jump_target;
    logic [`ADDR_W-1:0] cpu_addr;
    logic [`WORD_W-1:0] cpu_wdata;
    logic [`WORD_W-1:0] acc;
    logic [`ADDR_W-1:0] mem_addr;
    logic [`WORD_W-1:0] mem_wdata;
    logic               mem_we;
    logic [`WORD_W-1:0] mem_rdata;

    // loader owns the memory port whenever the cpu is idle
    assign mem_addr  = running ? cpu_addr  : load_addr;
    assign mem_wdata = running ? cpu_wdata : load_data;
    assign mem_we    = running ? cpu_we    : load_en;

    // OUT sends the accumulator as is
    assign out_data = acc;

    control_fsm u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .opcode        (opcode),
        .acc_zero      (acc_zero),
        .credit_return (credit_return),
        .pc_inc        (pc_inc),
        .pc_jump       (pc_jump),
        .pc_clear      (pc_clear),
        .mar_from_pc   (mar_from_pc),
        .mar_from_ir   (mar_from_ir),
        .mbr_load      (mbr_load),
        .ir_load       (ir_load),
        .acc_from_mbr  (acc_from_mbr),
        .acc_from_alu  (acc_from_alu),
        .mem_we        (cpu_we),
        .out_valid     (out_valid),
        .running       (running),
        .halted        (halted)
    );

    program_counter u_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .inc    (pc_inc),
        .jump   (pc_jump),
        .clear  (pc_clear),
        .target (jump_target),
        .pc     (pc)
    );

    datapath u_dp (
        .clk          (clk),
        .rst_n        (rst_n),
        .mar_from_pc  (mar_from_pc),
        .mar_from_ir  (mar_from_ir),
        .mbr_load     (mbr_load),
        .ir_load      (ir_load),
        .acc_from_mbr (acc_from_mbr),
        .acc_from_alu (acc_from_alu),
        .pc           (pc),
        .mem_rdata    (mem_rdata),
        .mem_addr     (cpu_addr),
        .mem_wdata    (cpu_wdata),
        .opcode       (opcode),
        .jump_target  (jump_target),
        .acc_zero     (acc_zero),
        .acc          (acc)
    );

    main_memory u_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

// File: tb/tb_acc_cpu.sv
`timescale 1ns/1ps
`include "acc_cpu_config.svh"

module tb_acc_cpu;
    import acc_cpu_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int IMG_WORDS    = 64;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               load_en;
    logic [`ADDR_W-1:0] load_addr;
    logic [`WORD_W-1:0] load_data;
    logic               start;
    logic               credit_return;
    logic               out_valid;
    logic [`WORD_W-1:0] out_data;
    logic               running;
    logic               halted;

    // program images loaded from address 0 upward
    logic [`WORD_W-1:0] img [0:1][0:IMG_WORDS-1];
    int                 img_len [0:1];
    // model memory and accumulator persist across programs like the dut
    logic [`WORD_W-1:0] mem_m [0:`MEM_DEPTH-1];
    logic [`WORD_W-1:0] acc_m;
    // predicted beats of both programs in one list
    logic [`WORD_W-1:0] exp_beats [0:63];
    logic [`WORD_W-1:0] exp_head;
    int                 exp_count;
    int                 exp_end [0:1];
    int                 beat_idx;
    int                 outstanding;
    int                 errors;
    int                 cycles;
    int                 cycle_limit = 1000000;
    logic [31:0]        lcg_state;
    int                 owed;
    int                 ret_wait;
    logic               ret_now;
    int                 steps [0:1];

    acc_cpu_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .start         (start),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .running       (running),
        .halted        (halted)
    );

    always #50 clk = ~clk;

    function int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // alu rules written out per function
    function automatic logic [15:0] alu_model(input logic [3:0] f, input logic [15:0] a,
                                              input logic [15:0] b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_MUL:  return a * b;
            ALU_DIV:  return (b == 16'h0) ? 16'hffff : a / b;
            ALU_SHL:  return a << 1;
            ALU_SHR:  return a >> 1;
            ALU_ROL:  return (a << 1) | (a >> 15);
            ALU_ROR:  return (a >> 1) | (a << 15);
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_NAND: return ~(a & b);
            ALU_XNOR: return ~(a ^ b);
            ALU_GT:   return (a > b) ? 16'd1 : 16'd0;
            default:  return (a == b) ? 16'd1 : 16'd0;
        endcase
    endfunction

    function automatic logic [15:0] mem_instr(input opcode_e op, input logic [11:0] a);
        return {op, a};
    endfunction

    function automatic logic [15:0] alu_instr(input alu_func_e f, input logic [7:0] imm);
        return {OP_ALUI, f, imm};
    endfunction

    task automatic add_word(input int p, input logic [15:0] w);
        img[p][img_len[p]] = w;
        img_len[p]++;
    endtask

    task automatic build_programs();
        img_len[0] = 0;
        img_len[1] = 0;
        // sweep starts from the data word at 39
        add_word(0, mem_instr(OP_LOAD, 12'd39));
        for (int f = 0; f < 16; f++) begin
            add_word(0, alu_instr(alu_func_e'(f), 8'(lcg_next())));
            add_word(0, mem_instr(OP_OUT, 12'd0));
        end
        // divide by zero
        add_word(0, alu_instr(ALU_DIV, 8'h00));
        add_word(0, mem_instr(OP_OUT, 12'd0));
        // force an equal compare that is true
        add_word(0, alu_instr(ALU_AND, 8'h00));
        add_word(0, alu_instr(ALU_EQ, 8'h00));
        add_word(0, mem_instr(OP_OUT, 12'd0));
        add_word(0, mem_instr(OP_HALT, 12'd0));
        add_word(0, 16'(lcg_next()));
        // countdown from the counter word at 8
        add_word(1, mem_instr(OP_LOAD, 12'd8));
        add_word(1, mem_instr(OP_JZ, 12'd7));
        add_word(1, mem_instr(OP_OUT, 12'd0));
        add_word(1, alu_instr(ALU_SUB, 8'd1));
        add_word(1, mem_instr(OP_STORE, 12'd8));
        add_word(1, mem_instr(OP_LOAD, 12'd8));
        add_word(1, mem_instr(OP_JUMP, 12'd1));
        add_word(1, mem_instr(OP_HALT, 12'd0));
        add_word(1, 16'd5);
    endtask

    // instruction set model runs from 0 until halt
    task automatic run_model(input int p, output int n);
        logic [11:0] pc;
        logic [15:0] w;
        bit          done;
        for (int i = 0; i < img_len[p]; i++) begin
            mem_m[i] = img[p][i];
        end
        pc   = '0;
        done = 1'b0;
        n    = 0;
        while (!done && n < 1000) begin
            w  = mem_m[pc];
            pc = pc + 1'b1;
            n++;
            case (w[15:12])
                OP_LOAD:  acc_m = mem_m[w[11:0]];
                OP_STORE: mem_m[w[11:0]] = acc_m;
                OP_ALUI:  acc_m = alu_model(w[11:8], acc_m, {8'h00, w[7:0]});
                OP_JUMP:  pc = w[11:0];
                OP_JZ:    if (acc_m == 16'h0) pc = w[11:0];
                OP_OUT: begin
                    exp_beats[exp_count] = acc_m;
                    exp_count++;
                end
                OP_HALT:  done = 1'b1;
                default:  ;
            endcase
        end
        exp_end[p] = exp_count;
    endtask

    task automatic load_program(input int p);
        for (int i = 0; i < img_len[p]; i++) begin
            load_en   = 1'b1;
            load_addr = `ADDR_W'(i);
            load_data = img[p][i];
            @(posedge clk);
            #10;
        end
        load_en = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #10;
        start = 1'b0;
    endtask

    task automatic wait_halt();
        while (!halted) begin
            @(posedge clk);
            #10;
        end
    endtask

    assign exp_head = exp_beats[beat_idx];

    always @(posedge clk) begin
        if (!rst_n) begin
            beat_idx    <= 0;
            outstanding <= 0;
        end else begin
            if (out_valid) beat_idx <= beat_idx + 1;
            outstanding <= outstanding + int'(out_valid) - int'(credit_return);
        end
    end

    // consumer returns one credit per beat after a random gap
    // gaps run long enough that the credit pool drains and OUT stalls
    always @(posedge clk) begin
        ret_now = 1'b0;
        if (!rst_n) begin
            owed     = 0;
            ret_wait = 0;
        end else begin
            if (out_valid) owed = owed + 1;
            if (owed > 0) begin
                if (ret_wait == 0) begin
                    ret_now  = 1'b1;
                    owed     = owed - 1;
                    ret_wait = lcg_next() % 32;
                end else begin
                    ret_wait = ret_wait - 1;
                end
            end
        end
        #10;
        credit_return = ret_now;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: no halt within %0d cycles", cycle_limit);
            $display("errors: %0d, beats seen: %0d of %0d", errors, beat_idx, exp_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    a_beat_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (beat_idx < exp_count) && (out_data == exp_head))
    else begin
        errors++;
        $display("** Error @ %0t: out_data %h, expected %h at beat %0d",
                 $time, $sampled(out_data), $sampled(exp_head), $sampled(beat_idx));
    end

    // beats in flight never exceed the credit pool
    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> outstanding < `OUT_CREDITS)
    else begin
        errors++;
        $display("beat sent with %0d credits already outstanding", $sampled(outstanding));
    end

    a_halt_state: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !running)
    else begin
        errors++;
        $display("halted and running high together at %0t", $time);
    end

    // idle machine sends nothing
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !running |-> !out_valid)
    else begin
        errors++;
        $display("out_valid high while not running at %0t", $time);
    end

    a_reset_quiet: assert property (@(posedge clk)
        $past(!rst_n) |-> !out_valid && !running && !halted)
    else begin
        errors++;
        $display("outputs not quiet during or right after reset at %0t", $time);
    end

    initial begin
        rst_n         = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        start         = 1'b0;
        credit_return = 1'b0;
        lcg_state     = 32'd4946;
        errors        = 0;
        cycles        = 0;
        exp_count     = 0;
        acc_m         = '0;
        build_programs();
        run_model(0, steps[0]);
        run_model(1, steps[1]);
        // 40 cycles per executed or loaded word plus reset
        cycle_limit = 40 * (steps[0] + steps[1] + img_len[0] + img_len[1]) + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int p = 0; p < 2; p++) begin
            load_program(p);
            pulse_start();
            wait_halt();
            // all beats of this program seen and none extra
            a_beat_count: assert (beat_idx == exp_end[p])
            else begin
                errors++;
                $display("** Error @ %0t: program %0d gave %0d beats in total, expected %0d",
                         $time, p, beat_idx, exp_end[p]);
            end
        end
        $display("errors: %0d, beats checked: %0d of %0d", errors, beat_idx, exp_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
design/acc_cpu_pkg.sv
design/alu.sv
design/main_memory.sv
design/program_counter.sv
design/datapath.sv
design/control_fsm.sv
design/acc_cpu_top.sv
tb/tb_acc_cpu.sv

// File: Bender.yml
package:
  name: acc_cpu

export_include_dirs:
  - include

sources:
  - files:
      - design/acc_cpu_pkg.sv
      - design/alu.sv
      - design/main_memory.sv
      - design/program_counter.sv
      - design/datapath.sv
      - design/control_fsm.sv
      - design/acc_cpu_top.sv
  - target: test
    files:
      - tb/tb_acc_cpu.sv
